// ==== exec_pkg.sv ====
package exec_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_sel_t;
    typedef logic [3:0]  cause_t;

    localparam cause_t CAUSE_MISALIGNED = 4'd0;
    localparam cause_t CAUSE_ILLEGAL    = 4'd2;

    // Major opcodes of the RV32I subset handled here
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [1:0] {
        UNIT_INT,
        UNIT_BRANCH,
        UNIT_NONE
    } unit_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA, PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR
    } br_op_t;

    typedef struct packed {
        instr_t instr;
        addr_t  pc;
        xlen_t  rs1_data;
        xlen_t  rs2_data;
    } in_pkt_t;

    typedef struct packed {
        unit_t    unit;
        alu_op_t  alu_op;
        br_op_t   br_op;
        addr_t    pc;
        reg_sel_t rd;
        logic     wr_en;
        xlen_t    operand_a;
        xlen_t    operand_b;
        xlen_t    rs1_value;
        xlen_t    rs2_value;
        xlen_t    imm;
        logic     illegal;
    } uop_t;

    typedef struct packed {
        xlen_t result;
        logic  taken;
        addr_t target;
        logic  misaligned;
    } unit_out_t;

    typedef struct packed {
        addr_t    pc;
        reg_sel_t rd;
        logic     wr_en;
        xlen_t    result;
        logic     exception;
        cause_t   cause;
        logic     redirect;
        addr_t    redirect_pc;
    } res_pkt_t;

endpackage

// ==== exec_decode.sv ====
module exec_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  exec_pkg::in_pkt_t in_pkt,
    output logic              dec_valid,
    input  logic              dec_ready,
    output exec_pkg::uop_t    uop,
    input  logic              fwd_valid,
    input  exec_pkg::reg_sel_t fwd_rd,
    input  exec_pkg::xlen_t   fwd_data,
    input  logic              redirect_fire
);
    import exec_pkg::*;

    typedef enum logic {
        KILL_IDLE,
        KILL_PENDING
    } kill_state_t;

    kill_state_t kill_state;
    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_sel_t    rd, rs1, rs2;
    xlen_t       i_imm, b_imm, u_imm, j_imm;
    uop_t        dec_d, dec_q;
    reg_sel_t    rs1_q, rs2_q;
    logic        a_pc_d, a_pc_q, b_imm_d, b_imm_q;
    logic        writes, illegal, accept;
    xlen_t       rs1_fwd, rs2_fwd;

    function automatic alu_op_t alu_from_funct3(input logic [2:0] f3);
        case (f3)
            3'b000:  return ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    assign opcode = opcode_t'(in_pkt.instr[6:0]);
    assign funct3 = in_pkt.instr[14:12];
    assign funct7 = in_pkt.instr[31:25];
    assign rd     = in_pkt.instr[11:7];
    assign rs1    = in_pkt.instr[19:15];
    assign rs2    = in_pkt.instr[24:20];

    assign i_imm = {{20{in_pkt.instr[31]}}, in_pkt.instr[31:20]};
    assign b_imm = {{19{in_pkt.instr[31]}}, in_pkt.instr[31], in_pkt.instr[7],
                    in_pkt.instr[30:25], in_pkt.instr[11:8], 1'b0};
    assign u_imm = {in_pkt.instr[31:12], 12'b0};
    assign j_imm = {{11{in_pkt.instr[31]}}, in_pkt.instr[31], in_pkt.instr[19:12],
                    in_pkt.instr[20], in_pkt.instr[30:21], 1'b0};

    always_comb begin
        dec_d           = '0;
        dec_d.unit      = UNIT_INT;
        dec_d.alu_op    = ADD;
        dec_d.br_op     = BEQ;
        dec_d.pc        = in_pkt.pc;
        dec_d.rd        = rd;
        dec_d.rs1_value = in_pkt.rs1_data;
        dec_d.rs2_value = in_pkt.rs2_data;
        a_pc_d  = 1'b0;
        b_imm_d = 1'b0;
        writes  = 1'b1;
        illegal = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    dec_d.alu_op = alu_from_funct3(funct3);
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec_d.alu_op = SUB;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    dec_d.alu_op = SRA;
                end else begin
                    illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                dec_d.alu_op = alu_from_funct3(funct3);
                dec_d.imm    = i_imm;
                b_imm_d      = 1'b1;
                // Shift amounts sit in the low immediate bits and funct7 must be clean
                if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
                    dec_d.alu_op = SRA;
                end else if ((funct3 == 3'b001 || funct3 == 3'b101) && funct7 != 7'b0) begin
                    illegal = 1'b1;
                end
            end
            OPC_LUI: begin
                dec_d.alu_op = PASS_B;
                dec_d.imm    = u_imm;
                b_imm_d      = 1'b1;
            end
            OPC_AUIPC: begin
                dec_d.imm = u_imm;
                a_pc_d    = 1'b1;
                b_imm_d   = 1'b1;
            end
            OPC_BRANCH: begin
                dec_d.unit = UNIT_BRANCH;
                dec_d.imm  = b_imm;
                writes     = 1'b0;
                case (funct3)
                    3'b000:  dec_d.br_op = BEQ;
                    3'b001:  dec_d.br_op = BNE;
                    3'b100:  dec_d.br_op = BLT;
                    3'b101:  dec_d.br_op = BGE;
                    3'b110:  dec_d.br_op = BLTU;
                    3'b111:  dec_d.br_op = BGEU;
                    default: illegal = 1'b1;
                endcase
            end
            OPC_JAL: begin
                dec_d.unit  = UNIT_BRANCH;
                dec_d.br_op = JAL;
                dec_d.imm   = j_imm;
            end
            OPC_JALR: begin
                dec_d.unit  = UNIT_BRANCH;
                dec_d.br_op = JALR;
                dec_d.imm   = i_imm;
                illegal     = funct3 != 3'b000;
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            dec_d.unit = UNIT_NONE;
        end
        dec_d.illegal = illegal;
        dec_d.wr_en   = writes && !illegal && rd != '0;
    end

    assign in_ready = !dec_valid || dec_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid  <= 1'b0;
            kill_state <= KILL_IDLE;
        end else begin
            // The instruction right after a redirect is on the wrong path
            if (accept) begin
                dec_valid <= !redirect_fire && kill_state == KILL_IDLE;
            end else if (dec_ready) begin
                dec_valid <= 1'b0;
            end
            if (accept && kill_state == KILL_PENDING) begin
                kill_state <= KILL_IDLE;
            end else if (redirect_fire && !accept) begin
                kill_state <= KILL_PENDING;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_q   <= dec_d;
            rs1_q   <= rs1;
            rs2_q   <= rs2;
            a_pc_q  <= a_pc_d;
            b_imm_q <= b_imm_d;
        end
    end

    // Forwarding works on the registered operands, so the record ahead is already in the
    // forwarding register when this one is presented to the units
    always_comb begin
        rs1_fwd = (fwd_valid && fwd_rd == rs1_q) ? fwd_data : dec_q.rs1_value;
        rs2_fwd = (fwd_valid && fwd_rd == rs2_q) ? fwd_data : dec_q.rs2_value;
        uop           = dec_q;
        uop.rs1_value = rs1_fwd;
        uop.rs2_value = rs2_fwd;
        uop.operand_a = a_pc_q ? dec_q.pc : rs1_fwd;
        uop.operand_b = b_imm_q ? dec_q.imm : rs2_fwd;
    end

endmodule

// ==== exec_int.sv ====
module exec_int (
    input  exec_pkg::uop_t      uop,
    output exec_pkg::unit_out_t int_out
);
    import exec_pkg::*;

    xlen_t      a, b;
    logic [4:0] shamt;
    xlen_t      result;

    assign a     = uop.operand_a;
    assign b     = uop.operand_b;
    assign shamt = b[4:0];

    always_comb begin
        case (uop.alu_op)
            ADD: begin
                result = a + b;
            end
            SUB: begin
                result = a - b;
            end
            AND: begin
                result = a & b;
            end
            OR: begin
                result = a | b;
            end
            XOR: begin
                result = a ^ b;
            end
            SLT: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            SLTU: begin
                result = {31'b0, a < b};
            end
            SLL: begin
                result = a << shamt;
            end
            SRL: begin
                result = a >> shamt;
            end
            SRA: begin
                result = xlen_t'($signed(a) >>> shamt);
            end
            default: begin
                // LUI passes its U immediate straight through
                result = b;
            end
        endcase
    end

    always_comb begin
        int_out            = '0;
        int_out.result     = result;
        int_out.taken      = 1'b0;
        int_out.target     = '0;
        int_out.misaligned = 1'b0;
    end

endmodule

// ==== exec_branch.sv ====
module exec_branch (
    input  exec_pkg::uop_t      uop,
    output exec_pkg::unit_out_t br_out
);
    import exec_pkg::*;

    xlen_t rs1, rs2;
    logic  eq, lt, ltu;
    logic  taken;
    addr_t target;
    addr_t link;

    assign rs1 = uop.rs1_value;
    assign rs2 = uop.rs2_value;
    assign eq  = rs1 == rs2;
    assign lt  = $signed(rs1) < $signed(rs2);
    assign ltu = rs1 < rs2;

    always_comb begin
        case (uop.br_op)
            BEQ:     taken = eq;
            BNE:     taken = !eq;
            BLT:     taken = lt;
            BGE:     taken = !lt;
            BLTU:    taken = ltu;
            BGEU:    taken = !ltu;
            default: taken = 1'b1;
        endcase
    end

    always_comb begin
        if (uop.br_op == JALR) begin
            target = (rs1 + uop.imm) & ~addr_t'(1);
        end else begin
            target = uop.pc + uop.imm;
        end
    end

    assign link = uop.pc + addr_t'(4);

    // Only a taken target can fault and without compressed instructions its bit 1 must be clear
    always_comb begin
        br_out            = '0;
        br_out.result     = link;
        br_out.taken      = taken;
        br_out.target     = target;
        br_out.misaligned = taken && target[1];
    end

endmodule

// ==== exec_result.sv ====
module exec_result #(
    parameter exec_pkg::addr_t TRAP_VECTOR = 32'h0000_0100
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                dec_valid,
    output logic                dec_ready,
    input  exec_pkg::uop_t      uop,
    input  exec_pkg::unit_out_t int_out,
    input  exec_pkg::unit_out_t br_out,
    output logic                out_valid,
    input  logic                out_ready,
    output exec_pkg::res_pkt_t  out_pkt,
    output logic                fwd_valid,
    output exec_pkg::reg_sel_t  fwd_rd,
    output exec_pkg::xlen_t     fwd_data,
    output logic                redirect_fire
);
    import exec_pkg::*;

    unit_out_t sel;
    res_pkt_t  rec;
    logic      move;
    logic      exc;

    assign sel = (uop.unit == UNIT_BRANCH) ? br_out : int_out;

    // An illegal instruction takes priority because it never reaches a unit
    assign exc = uop.illegal || sel.misaligned;

    always_comb begin
        rec           = '0;
        rec.pc        = uop.pc;
        rec.rd        = uop.rd;
        rec.wr_en     = uop.wr_en && !exc;
        rec.result    = uop.illegal ? '0 : sel.result;
        rec.exception = exc;
        if (uop.illegal) begin
            rec.cause = CAUSE_ILLEGAL;
        end else if (sel.misaligned) begin
            rec.cause = CAUSE_MISALIGNED;
        end
        if (exc) begin
            rec.redirect    = 1'b1;
            rec.redirect_pc = TRAP_VECTOR;
        end else if (sel.taken) begin
            // Prediction is static not-taken so every taken transfer is a mispredict
            rec.redirect    = 1'b1;
            rec.redirect_pc = sel.target;
        end
    end

    assign dec_ready     = !out_valid || out_ready;
    assign move          = dec_valid && dec_ready;
    assign redirect_fire = move && rec.redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (dec_ready) begin
            out_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            out_pkt <= rec;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_valid <= 1'b0;
        end else if (move && rec.wr_en) begin
            fwd_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (move && rec.wr_en) begin
            fwd_rd   <= rec.rd;
            fwd_data <= rec.result;
        end
    end

endmodule

// ==== exec_stage.sv ====
module exec_stage #(
    parameter exec_pkg::addr_t TRAP_VECTOR = 32'h0000_0100
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  exec_pkg::in_pkt_t  in_pkt,
    output logic               out_valid,
    input  logic               out_ready,
    output exec_pkg::res_pkt_t out_pkt
);
    import exec_pkg::*;

    logic      dec_valid, dec_ready;
    uop_t      uop;
    unit_out_t int_out, br_out;
    logic      fwd_valid;
    reg_sel_t  fwd_rd;
    xlen_t     fwd_data;
    logic      redirect_fire;

    exec_decode u_decode (
        .clk, .rst,
        .in_valid, .in_ready, .in_pkt,
        .dec_valid, .dec_ready, .uop,
        .fwd_valid, .fwd_rd, .fwd_data,
        .redirect_fire
    );

    exec_int u_int (.uop, .int_out);

    exec_branch u_branch (.uop, .br_out);

    exec_result #(
        .TRAP_VECTOR(TRAP_VECTOR)
    ) u_result (
        .clk, .rst,
        .dec_valid, .dec_ready, .uop,
        .int_out, .br_out,
        .out_valid, .out_ready, .out_pkt,
        .fwd_valid, .fwd_rd, .fwd_data,
        .redirect_fire
    );

endmodule

// ==== tb_exec_stage.sv ====
module tb_exec_stage;
    timeunit 1ns;
    timeprecision 1ns;
    import exec_pkg::*;

    localparam addr_t TRAP_ADDR  = 32'h0000_0200;
    localparam int    N_INSTR    = 400;
    localparam int    CLK_PERIOD = 20;

    logic     clk, rst;
    logic     in_valid, in_ready, out_valid, out_ready;
    in_pkt_t  in_pkt;
    res_pkt_t out_pkt;

    integer      seed;
    addr_t       pc;
    int          sent;
    logic        took;
    logic [31:0] r;
    res_pkt_t    exp_q[$];

    // Reference state holds the last written record and the wrong-path flag
    logic     mfwd_valid = 1'b0;
    reg_sel_t mfwd_rd    = '0;
    xlen_t    mfwd_data  = '0;
    logic     kill_next  = 1'b0;
    logic     held       = 1'b0;
    res_pkt_t held_pkt;

    exec_stage #(
        .TRAP_VECTOR(TRAP_ADDR)
    ) dut0 (
        .clk, .rst,
        .in_valid, .in_ready, .in_pkt,
        .out_valid, .out_ready, .out_pkt
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(N_INSTR * 6 * CLK_PERIOD + 200 * CLK_PERIOD);
        $display("Watchdog expired, the DUT made no progress");
        $display("TESTS FAILED");
        $fatal(1);
    end

    function automatic xlen_t alu_f3(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'd0: return a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // RV32I execution of one instruction as the retired record should show it
    function automatic res_pkt_t predict_record(input in_pkt_t p);
        instr_t     ins;
        xlen_t      a, b, i_imm, u_imm, tgt;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ill, taken, is_br, wr, mis;
        res_pkt_t   e;
        ins   = p.instr;
        f3    = ins[14:12];
        f7    = ins[31:25];
        a     = (mfwd_valid && mfwd_rd == ins[19:15]) ? mfwd_data : p.rs1_data;
        b     = (mfwd_valid && mfwd_rd == ins[24:20]) ? mfwd_data : p.rs2_data;
        i_imm = {{20{ins[31]}}, ins[31:20]};
        u_imm = {ins[31:12], 12'h000};
        e     = '0;
        e.pc  = p.pc;
        e.rd  = ins[11:7];
        ill   = 1'b0;
        taken = 1'b0;
        is_br = 1'b0;
        wr    = 1'b1;
        tgt   = '0;
        case (ins[6:0])
            7'h33: begin
                if (f7 == 7'h00) e.result = alu_f3(f3, a, b);
                else if (f7 == 7'h20 && f3 == 3'd0) e.result = a - b;
                else if (f7 == 7'h20 && f3 == 3'd5) e.result = $signed(a) >>> b[4:0];
                else ill = 1'b1;
            end
            7'h13: begin
                if (f3 == 3'd5 && f7 == 7'h20) e.result = $signed(a) >>> i_imm[4:0];
                else if ((f3 == 3'd1 || f3 == 3'd5) && f7 != 7'h00) ill = 1'b1;
                else e.result = alu_f3(f3, a, i_imm);
            end
            7'h37: e.result = u_imm;
            7'h17: e.result = p.pc + u_imm;
            7'h63: begin
                is_br = 1'b1;
                wr    = 1'b0;
                tgt   = p.pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                case (f3)
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    3'd7: taken = a >= b;
                    default: ill = 1'b1;
                endcase
            end
            7'h6f: begin
                is_br = 1'b1;
                taken = 1'b1;
                tgt   = p.pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                is_br = 1'b1;
                taken = 1'b1;
                ill   = f3 != 3'd0;
                tgt   = (a + i_imm) & ~32'd1;
            end
            default: ill = 1'b1;
        endcase
        if (is_br) e.result = p.pc + 32'd4;
        if (ill) e.result = '0;
        mis         = !ill && taken && tgt[1];
        e.exception = ill || mis;
        if (ill) e.cause = CAUSE_ILLEGAL;
        else if (mis) e.cause = CAUSE_MISALIGNED;
        e.wr_en = wr && !e.exception && e.rd != 5'd0;
        if (e.exception) begin
            e.redirect    = 1'b1;
            e.redirect_pc = TRAP_ADDR;
        end else if (taken) begin
            e.redirect    = 1'b1;
            e.redirect_pc = tgt;
        end
        return e;
    endfunction

    task automatic model_accept();
        res_pkt_t e;
        if (kill_next) begin
            kill_next = 1'b0;
        end else begin
            e = predict_record(in_pkt);
            exp_q.push_back(e);
            kill_next = e.redirect;
            if (e.wr_en) begin
                mfwd_valid = 1'b1;
                mfwd_rd    = e.rd;
                mfwd_data  = e.result;
            end
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] want,
                                 input logic [31:0] seen);
        assert (seen === want) else begin
            $display("ERR %0t out_pkt.%s exp=%h got=%h", $time, name, want, seen);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_record();
        res_pkt_t e;
        if (exp_q.size() == 0) begin
            $display("An output record appeared with no instruction left to retire");
            $display("TESTS FAILED");
            $fatal(1);
        end else begin
            e = exp_q.pop_front();
            compare_field("pc", e.pc, out_pkt.pc);
            compare_field("rd", 32'(e.rd), 32'(out_pkt.rd));
            compare_field("wr_en", 32'(e.wr_en), 32'(out_pkt.wr_en));
            compare_field("result", e.result, out_pkt.result);
            compare_field("exception", 32'(e.exception), 32'(out_pkt.exception));
            compare_field("cause", 32'(e.cause), 32'(out_pkt.cause));
            compare_field("redirect", 32'(e.redirect), 32'(out_pkt.redirect));
            compare_field("redirect_pc", e.redirect_pc, out_pkt.redirect_pc);
        end
    endtask

    // Only registers 0 to 7 are used so neighbouring instructions often depend on each other
    task automatic make_packet(output in_pkt_t p);
        logic [31:0] w, s;
        w = $random(seed);
        s = $random(seed);
        w[11:7]  = {2'b00, s[2:0]};
        w[19:15] = {2'b00, s[5:3]};
        case (s[11:9])
            3'd0: begin
                w[6:0]   = 7'h33;
                w[24:20] = {2'b00, s[8:6]};
                w[31:25] = s[12] ? 7'h20 : ((s[13] & s[14]) ? 7'h01 : 7'h00);
            end
            3'd1: begin
                w[6:0] = 7'h13;
                if (w[13:12] == 2'b01) w[31:25] = s[12] ? 7'h20 : 7'h00;
            end
            3'd2: w[6:0] = 7'h37;
            3'd3: w[6:0] = 7'h17;
            3'd4, 3'd5: begin
                w[6:0]   = 7'h63;
                w[24:20] = {2'b00, s[8:6]};
                w[8]     = s[12] & s[13];
            end
            3'd6: begin
                if (s[12]) begin
                    w[6:0] = 7'h6f;
                    w[21]  = s[13] & s[14];
                end else begin
                    w[6:0]   = 7'h67;
                    w[14:12] = (s[13] & s[14] & s[15]) ? 3'd1 : 3'd0;
                end
            end
            default: w[6:0] = s[12] ? 7'h73 : 7'h03;
        endcase
        p.instr    = w;
        p.pc       = pc;
        p.rs1_data = $random(seed);
        p.rs2_data = s[16] ? p.rs1_data : $random(seed);
        pc         = pc + 32'd4;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (held) begin
                assert (out_pkt === held_pkt) else begin
                    $display("ERR %0t out_pkt exp=%h got=%h", $time, held_pkt, out_pkt);
                    $display("TESTS FAILED");
                    $fatal(1);
                end
            end
            held     = out_valid && !out_ready;
            held_pkt = out_pkt;
            if (out_valid && out_ready) check_record();
            if (in_valid && in_ready) model_accept();
        end
    end

    initial begin
        seed      = 82263;
        pc        = 32'h0000_1000;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_pkt    = '0;
        out_ready = 1'b0;
        sent      = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (out_valid === 1'b0) else begin
            $display("ERR %0t out_valid exp=0 got=%b", $time, out_valid);
            $display("TESTS FAILED");
            $fatal(1);
        end
        while (sent < N_INSTR) begin
            @(posedge clk);
            took = in_valid && in_ready;
            #1;
            if (took) sent++;
            r         = $random(seed);
            out_ready = r[1:0] != 2'b00;
            // A presented packet is held until it is taken
            if (!in_valid || took) begin
                in_valid = 1'b0;
                if (sent < N_INSTR && r[3:2] != 2'b00) begin
                    make_packet(in_pkt);
                    in_valid = 1'b1;
                end
            end
        end
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            r         = $random(seed);
            out_ready = r[0] | r[1];
        end
        out_ready = 1'b1;
        repeat (4) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
exec_pkg.sv
exec_decode.sv
exec_int.sv
exec_branch.sv
exec_result.sv
exec_stage.sv
tb_exec_stage.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module tb_exec_stage -f list.f &&
    ./obj_dir/Vtb_exec_stage || exit 1
